// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Address map of the fetch path
  localparam int VADDR_W       = 32;
  localparam int PADDR_W       = 20;
  localparam int PAGE_BITS     = 12;
  localparam int PPN_W         = PADDR_W - PAGE_BITS;
  localparam int VPN_WALK_BITS = 10;

  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [PPN_W-1:0]   ppn_t;
  typedef logic [31:0]        instruction_t;

  // RISC-V mcause encoding
  typedef enum logic [3:0] {
    NO_EXCPT         = 4'd0,
    INSTR_PAGE_FAULT = 4'd12
  } excpt_cause_t;

  localparam vaddr_t RESET_PC = 32'h0000_1000;

  // Leaf PTE fields
  localparam int PTE_VALID_BIT = 0;
  localparam int PTE_PPN_LSB   = 8;

endpackage

`default_nettype wire

// File: common/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if #(
  parameter int AW = 20
);
  logic          cyc;
  logic          stb;
  logic          we;
  logic [AW-1:0] adr;
  logic [31:0]   dat_w;
  logic [31:0]   dat_r;
  logic          ack;

  modport master  (output cyc, stb, we, adr, dat_w, input  dat_r, ack);
  modport slave   (input  cyc, stb, we, adr, dat_w, output dat_r, ack);
  modport monitor (input  cyc, stb, we, adr, dat_w, dat_r, ack);
endinterface

`default_nettype wire

// File: fetch/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   redirect_i,
  input  fetch_pkg::vaddr_t      redirect_pc_i,
  input  logic                   dec_stall_i,
  // Translation
  output logic                   xlat_req_o,
  output fetch_pkg::vaddr_t      xlat_vaddr_o,
  input  logic                   xlat_done_i,
  input  fetch_pkg::paddr_t      xlat_paddr_i,
  input  logic                   xlat_fault_i,
  // Cache read
  output logic                   rd_req_o,
  output fetch_pkg::paddr_t      rd_addr_o,
  input  logic                   rd_valid_i,
  input  fetch_pkg::instruction_t rd_data_i,
  // Decode
  output logic                   dec_valid_o,
  output fetch_pkg::vaddr_t      dec_pc_o,
  output fetch_pkg::instruction_t dec_instr_o,
  output logic                   dec_excpt_o,
  output fetch_pkg::excpt_cause_t dec_excpt_cause_o
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    XLATE = 2'd0,
    READ  = 2'd1,
    DRAIN = 2'd2,
    HOLD  = 2'd3
  } state_t;

  state_t       state_q, state_d;
  vaddr_t       pc_q, pc_d;
  paddr_t       paddr_q;
  logic         load_instr;
  logic         load_fault;

  // Stall buffer
  instruction_t buf_instr_q;
  logic         buf_excpt_q;

  always_comb begin
    state_d    = state_q;
    pc_d       = pc_q;
    load_instr = 1'b0;
    load_fault = 1'b0;
    case (state_q)
      XLATE: begin
        if (xlat_done_i) begin
          load_fault = xlat_fault_i;
          state_d    = xlat_fault_i ? HOLD : READ;
        end
      end
      READ: begin
        if (rd_valid_i) begin
          load_instr = 1'b1;
          state_d    = HOLD;
        end
      end
      DRAIN: begin
        // Old read finishes, result thrown away
        if (rd_valid_i) state_d = XLATE;
      end
      HOLD: begin
        if (!dec_stall_i) begin
          pc_d    = pc_q + 32'd4;
          state_d = XLATE;
        end
      end
      default: state_d = XLATE;
    endcase

    if (redirect_i) begin
      pc_d = redirect_pc_i;
      if ((state_q == READ || state_q == DRAIN) && !rd_valid_i) begin
        state_d = DRAIN;
      end else begin
        state_d = XLATE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q     <= XLATE;
      pc_q        <= RESET_PC;
      buf_excpt_q <= 1'b0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      if (load_fault) buf_excpt_q <= 1'b1;
      if (load_instr) buf_excpt_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == XLATE && xlat_done_i) paddr_q <= xlat_paddr_i;
    if (load_instr) buf_instr_q <= rd_data_i;
    if (load_fault) buf_instr_q <= '0;
  end

  assign xlat_req_o   = (state_q == XLATE);
  assign xlat_vaddr_o = pc_q;

  // Request stays up through DRAIN until the cache answers
  assign rd_req_o  = (state_q == READ) || (state_q == DRAIN);
  assign rd_addr_o = paddr_q;

  assign dec_valid_o       = (state_q == HOLD);
  assign dec_pc_o          = pc_q;
  assign dec_instr_o       = buf_instr_q;
  assign dec_excpt_o       = buf_excpt_q;
  assign dec_excpt_cause_o = buf_excpt_q ? INSTR_PAGE_FAULT : NO_EXCPT;

endmodule

`default_nettype wire

// File: fetch/instr_cache.sv
`timescale 1ns/1ps
`default_nettype none

module instr_cache #(
  parameter int CACHE_LINES = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    rd_req_i,
  input  fetch_pkg::paddr_t       rd_addr_i,
  output logic                    rd_valid_o,
  output fetch_pkg::instruction_t rd_data_o,
  wb_if.master                    wb_cache
);
  import fetch_pkg::*;

  localparam int IDX_W = $clog2(CACHE_LINES);
  localparam int TAG_W = PADDR_W - 4 - IDX_W;

  typedef enum logic [1:0] {
    C_IDLE   = 2'd0,
    C_CHECK  = 2'd1,
    C_REFILL = 2'd2
  } state_t;

  state_t                 state_q;
  paddr_t                 req_addr_q;
  logic [1:0]             word_q;
  logic                   cyc_q;
  logic [CACHE_LINES-1:0] valid_q;
  logic [TAG_W-1:0]       tag_q [CACHE_LINES];
  instruction_t           data_q [CACHE_LINES*4];

  logic [IDX_W-1:0]       idx;
  logic [TAG_W-1:0]       req_tag;
  logic                   hit;
  logic                   fill_ack;

  assign idx      = req_addr_q[4 +: IDX_W];
  assign req_tag  = req_addr_q[PADDR_W-1 -: TAG_W];
  assign hit      = valid_q[idx] && (tag_q[idx] == req_tag);
  assign fill_ack = (state_q == C_REFILL) && cyc_q && wb_cache.ack;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= C_IDLE;
      cyc_q   <= 1'b0;
      word_q  <= '0;
      valid_q <= '0;
    end else begin
      case (state_q)
        C_IDLE: if (rd_req_i) state_q <= C_CHECK;
        C_CHECK: begin
          if (hit) begin
            state_q <= C_IDLE;
          end else begin
            state_q <= C_REFILL;
            word_q  <= '0;
            cyc_q   <= 1'b1;
          end
        end
        C_REFILL: begin
          // One Wishbone cycle per word, with a gap between them
          if (!cyc_q) begin
            cyc_q <= 1'b1;
          end else if (wb_cache.ack) begin
            cyc_q  <= 1'b0;
            word_q <= word_q + 2'd1;
            if (word_q == 2'd3) begin
              valid_q[idx] <= 1'b1;
              state_q      <= C_CHECK;
            end
          end
        end
        default: state_q <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == C_IDLE && rd_req_i) req_addr_q <= rd_addr_i;
    if (fill_ack) data_q[{idx, word_q}] <= wb_cache.dat_r;
    if (fill_ack && word_q == 2'd3) tag_q[idx] <= req_tag;
  end

  assign rd_valid_o = (state_q == C_CHECK) && hit;
  assign rd_data_o  = data_q[{idx, req_addr_q[3:2]}];

  assign wb_cache.cyc   = cyc_q;
  assign wb_cache.stb   = cyc_q;
  assign wb_cache.we    = 1'b0;
  assign wb_cache.adr   = {req_addr_q[PADDR_W-1:4], word_q, 2'b00};
  assign wb_cache.dat_w = '0;

endmodule

`default_nettype wire

// File: fetch/instr_mmu.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mmu #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              vm_en_i,
  input  fetch_pkg::ppn_t   satp_ppn_i,
  input  logic              tlb_flush_i,
  input  logic              xlat_req_i,
  input  fetch_pkg::vaddr_t xlat_vaddr_i,
  output logic              xlat_done_o,
  output fetch_pkg::paddr_t xlat_paddr_o,
  output logic              xlat_fault_o,
  wb_if.master              wb_ptw
);
  import fetch_pkg::*;

  localparam int PTR_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0]   tlb_valid_q;
  logic [VPN_WALK_BITS-1:0] tlb_vpn_q [TLB_ENTRIES];
  ppn_t                     tlb_ppn_q [TLB_ENTRIES];
  logic [PTR_W-1:0]         rr_q;

  // Last VPN whose PTE came back invalid
  logic                     fault_v_q;
  logic [VPN_WALK_BITS-1:0] fault_vpn_q;

  logic                     cyc_q;
  paddr_t                   walk_adr_q;
  logic [VPN_WALK_BITS-1:0] walk_vpn_q;

  logic [VPN_WALK_BITS-1:0] vpn_idx;
  logic                     vpn_high;
  logic                     tlb_hit;
  ppn_t                     tlb_ppn;
  logic                     fault;
  logic                     pte_valid;

  assign vpn_idx  = xlat_vaddr_i[PAGE_BITS +: VPN_WALK_BITS];
  assign vpn_high = |xlat_vaddr_i[VADDR_W-1:PAGE_BITS+VPN_WALK_BITS];

  always_comb begin
    tlb_hit = 1'b0;
    tlb_ppn = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (tlb_valid_q[i] && tlb_vpn_q[i] == vpn_idx) begin
        tlb_hit = 1'b1;
        tlb_ppn = tlb_ppn_q[i];
      end
    end
  end

  assign fault = vpn_high || (fault_v_q && fault_vpn_q == vpn_idx);

  assign xlat_done_o  = xlat_req_i && (!vm_en_i || tlb_hit || fault);
  assign xlat_fault_o = vm_en_i && fault;
  assign xlat_paddr_o = vm_en_i ? {tlb_ppn, xlat_vaddr_i[PAGE_BITS-1:0]}
                                : xlat_vaddr_i[PADDR_W-1:0];

  assign pte_valid = wb_ptw.dat_r[PTE_VALID_BIT];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      cyc_q       <= 1'b0;
      tlb_valid_q <= '0;
      rr_q        <= '0;
      fault_v_q   <= 1'b0;
    end else begin
      if (!cyc_q && xlat_req_i && vm_en_i && !tlb_hit && !fault) begin
        cyc_q <= 1'b1;
      end else if (cyc_q && wb_ptw.ack) begin
        cyc_q <= 1'b0;
        if (pte_valid) begin
          tlb_valid_q[rr_q] <= 1'b1;
          rr_q <= (rr_q == PTR_W'(TLB_ENTRIES - 1)) ? '0 : rr_q + 1'b1;
        end else begin
          fault_v_q <= 1'b1;
        end
      end
      if (tlb_flush_i) begin
        tlb_valid_q <= '0;
        fault_v_q   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!cyc_q) begin
      walk_adr_q <= {satp_ppn_i, vpn_idx, 2'b00};
      walk_vpn_q <= vpn_idx;
    end
    if (cyc_q && wb_ptw.ack) begin
      tlb_vpn_q[rr_q] <= walk_vpn_q;
      tlb_ppn_q[rr_q] <= wb_ptw.dat_r[PTE_PPN_LSB +: PPN_W];
      if (!pte_valid) fault_vpn_q <= walk_vpn_q;
    end
  end

  assign wb_ptw.cyc   = cyc_q;
  assign wb_ptw.stb   = cyc_q;
  assign wb_ptw.we    = 1'b0;
  assign wb_ptw.adr   = walk_adr_q;
  assign wb_ptw.dat_w = '0;

endmodule

`default_nettype wire

// File: sim.f
common/fetch_pkg.sv
common/wb_if.sv
fetch/fetch_stage.sv
fetch/instr_mmu.sv
fetch/instr_cache.sv
src/wb_arbiter.sv
src/fetch_top.sv
testbench/fetch_properties.sv
testbench/fetch_checker.sv
testbench/tb_fetch.sv

// File: src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter int CACHE_LINES = 16,
  parameter int TLB_ENTRIES = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    redirect_i,
  input  fetch_pkg::vaddr_t       redirect_pc_i,
  input  logic                    vm_en_i,
  input  fetch_pkg::ppn_t         satp_ppn_i,
  input  logic                    tlb_flush_i,
  input  logic                    dec_stall_i,
  output logic                    dec_valid_o,
  output fetch_pkg::vaddr_t       dec_pc_o,
  output fetch_pkg::instruction_t dec_instr_o,
  output logic                    dec_excpt_o,
  output fetch_pkg::excpt_cause_t dec_excpt_cause_o,
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output fetch_pkg::paddr_t       wb_adr_o,
  output logic [31:0]             wb_dat_o,
  input  logic [31:0]             wb_dat_i,
  input  logic                    wb_ack_i
);
  import fetch_pkg::*;

  logic         xlat_req;
  vaddr_t       xlat_vaddr;
  logic         xlat_done;
  paddr_t       xlat_paddr;
  logic         xlat_fault;
  logic         rd_req;
  paddr_t       rd_addr;
  logic         rd_valid;
  instruction_t rd_data;

  wb_if #(.AW(PADDR_W)) wb_ptw ();
  wb_if #(.AW(PADDR_W)) wb_cache ();
  wb_if #(.AW(PADDR_W)) wb_mem ();

  fetch_stage u_stage (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .redirect_i        (redirect_i),
    .redirect_pc_i     (redirect_pc_i),
    .dec_stall_i       (dec_stall_i),
    .xlat_req_o        (xlat_req),
    .xlat_vaddr_o      (xlat_vaddr),
    .xlat_done_i       (xlat_done),
    .xlat_paddr_i      (xlat_paddr),
    .xlat_fault_i      (xlat_fault),
    .rd_req_o          (rd_req),
    .rd_addr_o         (rd_addr),
    .rd_valid_i        (rd_valid),
    .rd_data_i         (rd_data),
    .dec_valid_o       (dec_valid_o),
    .dec_pc_o          (dec_pc_o),
    .dec_instr_o       (dec_instr_o),
    .dec_excpt_o       (dec_excpt_o),
    .dec_excpt_cause_o (dec_excpt_cause_o)
  );

  instr_mmu #(.TLB_ENTRIES(TLB_ENTRIES)) u_mmu (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .vm_en_i      (vm_en_i),
    .satp_ppn_i   (satp_ppn_i),
    .tlb_flush_i  (tlb_flush_i),
    .xlat_req_i   (xlat_req),
    .xlat_vaddr_i (xlat_vaddr),
    .xlat_done_o  (xlat_done),
    .xlat_paddr_o (xlat_paddr),
    .xlat_fault_o (xlat_fault),
    .wb_ptw       (wb_ptw.master)
  );

  instr_cache #(.CACHE_LINES(CACHE_LINES)) u_cache (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_req_i   (rd_req),
    .rd_addr_i  (rd_addr),
    .rd_valid_o (rd_valid),
    .rd_data_o  (rd_data),
    .wb_cache   (wb_cache.master)
  );

  wb_arbiter u_arb (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .m0    (wb_ptw.slave),
    .m1    (wb_cache.slave),
    .mem   (wb_mem.master)
  );

  // Memory port as plain pins
  assign wb_cyc_o      = wb_mem.cyc;
  assign wb_stb_o      = wb_mem.stb;
  assign wb_we_o       = wb_mem.we;
  assign wb_adr_o      = wb_mem.adr;
  assign wb_dat_o      = wb_mem.dat_w;
  assign wb_mem.dat_r  = wb_dat_i;
  assign wb_mem.ack    = wb_ack_i;

endmodule

`default_nettype wire

// File: src/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
  input  logic clk_i,
  input  logic rst_i,
  wb_if.slave  m0,
  wb_if.slave  m1,
  wb_if.master mem
);

  logic busy_q;
  logic owner_q;
  logic sel;

  // m0 wins when the bus is free
  assign sel = busy_q ? owner_q : !m0.cyc;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (busy_q) begin
      if (!(owner_q ? m1.cyc : m0.cyc)) busy_q <= 1'b0;
    end else if (m0.cyc || m1.cyc) begin
      busy_q  <= 1'b1;
      owner_q <= sel;
    end
  end

  assign mem.cyc   = sel ? m1.cyc   : m0.cyc;
  assign mem.stb   = sel ? m1.stb   : m0.stb;
  assign mem.we    = sel ? m1.we    : m0.we;
  assign mem.adr   = sel ? m1.adr   : m0.adr;
  assign mem.dat_w = sel ? m1.dat_w : m0.dat_w;

  // Losing master keeps waiting on a low ack
  assign m0.ack   = mem.ack && !sel;
  assign m1.ack   = mem.ack && sel;
  assign m0.dat_r = mem.dat_r;
  assign m1.dat_r = mem.dat_r;

endmodule

`default_nettype wire

// File: testbench/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    redirect_i,
  input  fetch_pkg::vaddr_t       redirect_pc_i,
  input  logic                    vm_en_i,
  input  logic                    dec_stall_i,
  input  logic                    dec_valid_i,
  input  fetch_pkg::vaddr_t       dec_pc_i,
  input  fetch_pkg::instruction_t dec_instr_i,
  input  logic                    dec_excpt_i,
  input  fetch_pkg::excpt_cause_t dec_excpt_cause_i,
  output int                      err_cnt_o,
  output int                      check_cnt_o
);
  import fetch_pkg::*;

  vaddr_t exp_pc;
  int     errors = 0;
  int     checks = 0;

  // VPN 3 has an invalid PTE, VPN bits above the walk index are illegal
  function automatic logic page_fault(vaddr_t pc, logic vm);
    if (!vm) return 1'b0;
    if (pc[31:22] != '0) return 1'b1;
    return pc[21:12] == 10'd3;
  endfunction

  // Page table maps VPN k to PPN k + 0x10
  function automatic paddr_t phys_addr(vaddr_t pc, logic vm);
    logic [7:0] ppn;
    if (!vm) return pc[19:0];
    ppn = pc[19:12] + 8'h10;
    return {ppn, pc[11:0]};
  endfunction

  always @(negedge clk_i) begin
    logic         flt;
    instruction_t exp_instr;
    if (!rst_i) begin
      exp_pc = RESET_PC;
    end else if (redirect_i) begin
      exp_pc = redirect_pc_i;
    end else if (dec_valid_i && !dec_stall_i) begin
      flt       = page_fault(exp_pc, vm_en_i);
      exp_instr = {12'h000, phys_addr(exp_pc, vm_en_i)} ^ 32'hA5A5_0000;
      checks++;
      if (dec_pc_i !== exp_pc) begin
        errors++;
        $display("ERROR dec_pc_o: expected %h, got %h", exp_pc, dec_pc_i);
      end
      if (dec_excpt_i !== flt) begin
        errors++;
        $display("ERROR dec_excpt_o: expected %h, got %h", flt, dec_excpt_i);
      end
      if (dec_excpt_cause_i !== (flt ? INSTR_PAGE_FAULT : NO_EXCPT)) begin
        errors++;
        $display("ERROR dec_excpt_cause_o: expected %h, got %h",
                 flt ? INSTR_PAGE_FAULT : NO_EXCPT, dec_excpt_cause_i);
      end
      if (!flt && dec_instr_i !== exp_instr) begin
        errors++;
        $display("ERROR dec_instr_o: expected %h, got %h", exp_instr, dec_instr_i);
      end
      exp_pc = exp_pc + 32'd4;
    end
  end

  assign err_cnt_o   = errors;
  assign check_cnt_o = checks;

endmodule

`default_nettype wire

// File: testbench/fetch_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_properties (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    redirect_i,
  input  logic                    dec_stall_i,
  input  logic                    dec_valid_i,
  input  fetch_pkg::vaddr_t       dec_pc_i,
  input  fetch_pkg::instruction_t dec_instr_i,
  input  logic                    dec_excpt_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  fetch_pkg::paddr_t       wb_adr_i,
  input  logic [31:0]             wb_wdat_i,
  input  logic                    wb_ack_i
);

  int fail_cnt = 0;

  stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_stb_i |-> wb_cyc_i)
    else begin
      $error("Wishbone stb high without cyc");
      fail_cnt++;
    end

  we_low: assert property (@(posedge clk_i) disable iff (!rst_i) !wb_we_i)
    else begin
      $error("Wishbone we high on a read-only port");
      fail_cnt++;
    end

  // Read-only port drives no write data
  wdat_zero: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_cyc_i |-> (wb_wdat_i == '0))
    else begin
      $error("Wishbone write data not zero on a read-only port");
      fail_cnt++;
    end

  // Address held until the slave answers
  adr_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
    (wb_cyc_i && wb_stb_i && !wb_ack_i) |=> $stable(wb_adr_i))
    else begin
      $error("Wishbone address changed before ack");
      fail_cnt++;
    end

  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
    (dec_valid_i && dec_stall_i && !redirect_i) |=>
      (dec_valid_i && $stable(dec_pc_i) && $stable(dec_instr_i) && $stable(dec_excpt_i)))
    else begin
      $error("Decode outputs changed during a stall");
      fail_cnt++;
    end

endmodule

bind fetch_top fetch_properties u_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .redirect_i  (redirect_i),
  .dec_stall_i (dec_stall_i),
  .dec_valid_i (dec_valid_o),
  .dec_pc_i    (dec_pc_o),
  .dec_instr_i (dec_instr_o),
  .dec_excpt_i (dec_excpt_o),
  .wb_cyc_i    (wb_cyc_o),
  .wb_stb_i    (wb_stb_o),
  .wb_we_i     (wb_we_o),
  .wb_adr_i    (wb_adr_o),
  .wb_wdat_i   (wb_dat_o),
  .wb_ack_i    (wb_ack_i)
);

`default_nettype wire

// File: testbench/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;
  import fetch_pkg::*;

  localparam int ROWS = 9;

  logic         clk_i = 1'b0;
  logic         rst_i;
  logic         redirect_i;
  vaddr_t       redirect_pc_i;
  logic         vm_en_i;
  ppn_t         satp_ppn_i;
  logic         tlb_flush_i;
  logic         dec_stall_i;
  logic         dec_valid_o;
  vaddr_t       dec_pc_o;
  instruction_t dec_instr_o;
  logic         dec_excpt_o;
  excpt_cause_t dec_excpt_cause_o;
  logic         wb_cyc_o;
  logic         wb_stb_o;
  logic         wb_we_o;
  paddr_t       wb_adr_o;
  logic [31:0]  wb_dat_o;
  logic [31:0]  wb_dat_i = '0;
  logic         wb_ack_i = 1'b0;

  int           err_cnt;
  int           check_cnt;
  int           cycles = 0;
  int           limit = 0;
  int           total = 0;

  // Row: redirect PC, vm_en, instructions to consume, stall pattern
  vaddr_t       row_pc    [ROWS] = '{32'h1000, 32'h2ff0, 32'h1000, 32'h0ff8, 32'h3000,
                                     32'h0040_0000, 32'h1000, 32'h6ff8, 32'h5000};
  logic         row_vm    [ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
  int           row_cnt   [ROWS] = '{12, 10, 8, 6, 3, 2, 8, 4, 6};
  logic [7:0]   row_stall [ROWS] = '{8'h00, 8'h5a, 8'h00, 8'h33, 8'h00,
                                     8'h81, 8'hc3, 8'h96, 8'hee};

  logic [31:0]  mem [262144];
  logic         mem_busy = 1'b0;
  int           mem_wait = 0;

  always #4 clk_i = !clk_i;

  fetch_top #(.CACHE_LINES(16), .TLB_ENTRIES(4)) u_dut (.*);

  fetch_checker u_check (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .redirect_i        (redirect_i),
    .redirect_pc_i     (redirect_pc_i),
    .vm_en_i           (vm_en_i),
    .dec_stall_i       (dec_stall_i),
    .dec_valid_i       (dec_valid_o),
    .dec_pc_i          (dec_pc_o),
    .dec_instr_i       (dec_instr_o),
    .dec_excpt_i       (dec_excpt_o),
    .dec_excpt_cause_i (dec_excpt_cause_o),
    .err_cnt_o         (err_cnt),
    .check_cnt_o       (check_cnt)
  );

  // Code everywhere, page table at PPN 0x20
  initial begin
    for (int i = 0; i < 262144; i++) begin
      mem[i] = (i * 4) ^ 32'hA5A5_0000;
    end
    for (int k = 0; k < 8; k++) begin
      mem[32'h8000 + k] = ((k + 32'h10) << 8) | ((k == 3) ? 32'h0 : 32'h1);
    end
  end

  // Wishbone slave with 0 to 3 random wait cycles
  always @(posedge clk_i) begin
    #1;
    if (wb_ack_i) begin
      wb_ack_i = 1'b0;
    end else if (rst_i && wb_cyc_o && wb_stb_o) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_wait = $urandom % 4;
      end
      if (mem_wait == 0) begin
        wb_dat_i = mem[wb_adr_o[19:2]];
        wb_ack_i = 1'b1;
        mem_busy = 1'b0;
      end else begin
        mem_wait--;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, %0d instructions checked", cycles, check_cnt);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int n;
    int k;
    void'($urandom(48));
    rst_i         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    vm_en_i       = 1'b0;
    satp_ppn_i    = 8'h20;
    tlb_flush_i   = 1'b0;
    dec_stall_i   = 1'b0;
    for (int r = 0; r < ROWS; r++) total += row_cnt[r];
    limit = total * 40;

    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b1;

    for (int r = 0; r < ROWS; r++) begin
      // Row 0 starts from the reset PC
      if (r > 0) begin
        // Next fetch reaches the cache, so a miss is still refilling here
        dec_stall_i = 1'b1;
        repeat (2) @(posedge clk_i);
        #1;
        redirect_i    = 1'b1;
        redirect_pc_i = row_pc[r];
        vm_en_i       = row_vm[r];
        dec_stall_i   = 1'b1;
        @(posedge clk_i);
        #1;
        redirect_i = 1'b0;
      end
      n = 0;
      k = 0;
      while (n < row_cnt[r]) begin
        dec_stall_i = row_stall[r][k % 8];
        k++;
        @(negedge clk_i);
        if (dec_valid_o && !dec_stall_i) n++;
        @(posedge clk_i);
        #1;
      end
    end

    dec_stall_i = 1'b1;
    repeat (4) @(posedge clk_i);
    if (check_cnt != total) begin
      $display("Checker saw %0d instructions but %0d were consumed", check_cnt, total);
    end
    $display("checks %0d errors %0d assertion failures %0d", check_cnt, err_cnt,
             u_dut.u_props.fail_cnt);
    if (err_cnt == 0 && check_cnt == total && u_dut.u_props.fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
